// ==== common/dec_pkg.sv ====
`default_nettype none

package dec_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_adr_t;
    typedef logic [1:0]  alu_cmd_t;
    typedef logic        select_op_t;
    typedef logic [1:0]  mem_size_t;

    // ----------------------------------------
    // Major opcodes
    // ----------------------------------------
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;

    localparam word_t INC_VALUE = 32'd4;

    // Sub-commands of the adder/logic unit and the shifter
    localparam alu_cmd_t CMD_ADD_SLL = 2'd0;
    localparam alu_cmd_t CMD_AND_SRL = 2'd1;
    localparam alu_cmd_t CMD_OR_SRA  = 2'd2;
    localparam alu_cmd_t CMD_XOR     = 2'd3;

    localparam select_op_t SEL_ALU   = 1'b0;
    localparam select_op_t SEL_SHIFT = 1'b1;

    localparam mem_size_t MEM_WORD = 2'd0;
    localparam mem_size_t MEM_HALF = 2'd1;
    localparam mem_size_t MEM_BYTE = 2'd2;
    localparam mem_size_t MEM_NONE = 2'd3;

    // Branch conditions taken straight from funct3
    localparam logic [2:0] BR_EQ  = 3'b000;
    localparam logic [2:0] BR_NE  = 3'b001;
    localparam logic [2:0] BR_LT  = 3'b100;
    localparam logic [2:0] BR_GE  = 3'b101;
    localparam logic [2:0] BR_LTU = 3'b110;
    localparam logic [2:0] BR_GEU = 3'b111;

    typedef struct packed {
        logic       is_op;
        logic       is_store;
        logic       is_branch;
        logic       is_lui;
        logic       is_auipc;
        logic       is_jal;
        logic       is_jalr;
        reg_adr_t   rs1;
        logic       rs1_used;
        reg_adr_t   rs2;
        logic       rs2_used;
        reg_adr_t   rd;
        alu_cmd_t   alu_cmd;
        select_op_t select_op;
        logic       neg_op2;
        logic       slt;
        logic       sltu;
        logic       wb;
        logic       mem_load;
        logic       mem_store;
        logic       mem_sign_extend;
        mem_size_t  mem_size;
        word_t      imm;
        logic [2:0] br_cond;
        logic       illegal;
    } dec_ctrl_t;

    typedef struct packed {
        logic     valid;
        reg_adr_t dest;
        word_t    result;
        logic     load;
    } bypass_src_t;

    typedef struct packed {
        word_t      pc;
        word_t      op1;
        word_t      op2;
        word_t      mem_data;
        reg_adr_t   dest;
        reg_adr_t   radr1;
        reg_adr_t   radr2;
        logic       r1_valid;
        logic       r2_valid;
        alu_cmd_t   alu_cmd;
        select_op_t select_op;
        logic       neg_op2;
        logic       slt;
        logic       sltu;
        logic       wb;
        logic       mem_load;
        logic       mem_store;
        logic       mem_sign_extend;
        mem_size_t  mem_size;
        logic       illegal;
    } dec2exe_t;

endpackage

`default_nettype wire

// ==== hdl/dec_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module dec_fifo #(
    parameter int WIDTH = 32
) (
    input  logic             clk,
    input  logic             reset_n,
    input  logic [WIDTH-1:0] din,
    input  logic             push,
    input  logic             pop,
    output logic [WIDTH-1:0] dout,
    output logic             full,
    output logic             empty
);

    logic             occupied;
    logic [WIDTH-1:0] data;

    // Occupancy flag
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            occupied <= 1'b0;
        end else if (push && !occupied) begin
            occupied <= 1'b1;
        end else if (pop && occupied) begin
            occupied <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (push && !occupied) begin
            data <= din;
        end
    end

    assign dout  = data;
    assign full  = occupied;
    assign empty = !occupied;

endmodule

`default_nettype wire

// ==== decode/instr_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module instr_decoder (
    input  dec_pkg::word_t     instr,
    output dec_pkg::dec_ctrl_t ctrl
);

    import dec_pkg::*;

    logic [2:0] funct3;
    logic [6:0] funct7;
    word_t      imm_i;
    word_t      imm_s;
    word_t      imm_u;

    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_u = {instr[31:12], 12'h000};

    always_comb begin
        ctrl          = '0;
        ctrl.mem_size = MEM_NONE;
        ctrl.br_cond  = funct3;

        // ----------------------------------------
        // Instruction class
        // ----------------------------------------
        case (instr[6:0])
            OPC_OP: begin
                ctrl.is_op    = 1'b1;
                ctrl.rs1_used = 1'b1;
                ctrl.rs2_used = 1'b1;
                ctrl.wb       = 1'b1;
                ctrl.illegal  = !(funct7 == 7'b0000000 ||
                    (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101)));
            end
            OPC_OP_IMM: begin
                ctrl.rs1_used = 1'b1;
                ctrl.wb       = 1'b1;
                ctrl.imm      = imm_i;
                if (funct3 == 3'b001) begin
                    ctrl.illegal = funct7 != 7'b0000000;
                end else if (funct3 == 3'b101) begin
                    ctrl.illegal = funct7 != 7'b0000000 && funct7 != 7'b0100000;
                end
            end
            OPC_LOAD: begin
                ctrl.mem_load = 1'b1;
                ctrl.rs1_used = 1'b1;
                ctrl.wb       = 1'b1;
                ctrl.imm      = imm_i;
                ctrl.illegal  = funct3[1:0] == 2'b11 || funct3 == 3'b110;
                // Only lb and lh are sign extended
                ctrl.mem_sign_extend = !funct3[2] && funct3[1:0] != 2'b10;
            end
            OPC_STORE: begin
                ctrl.is_store  = 1'b1;
                ctrl.mem_store = 1'b1;
                ctrl.rs1_used  = 1'b1;
                ctrl.rs2_used  = 1'b1;
                ctrl.imm       = imm_s;
                ctrl.illegal   = funct3[2] || funct3[1:0] == 2'b11;
            end
            OPC_BRANCH: begin
                ctrl.is_branch = 1'b1;
                ctrl.rs1_used  = 1'b1;
                ctrl.rs2_used  = 1'b1;
                ctrl.illegal   = funct3[2:1] == 2'b01;
            end
            OPC_LUI: begin
                ctrl.is_lui = 1'b1;
                ctrl.wb     = 1'b1;
                ctrl.imm    = imm_u;
            end
            OPC_AUIPC: begin
                ctrl.is_auipc = 1'b1;
                ctrl.wb       = 1'b1;
                ctrl.imm      = imm_u;
            end
            OPC_JAL: begin
                ctrl.is_jal = 1'b1;
                ctrl.wb     = 1'b1;
            end
            OPC_JALR: begin
                ctrl.is_jalr  = 1'b1;
                ctrl.rs1_used = 1'b1;
                ctrl.wb       = 1'b1;
                ctrl.illegal  = funct3 != 3'b000;
            end
            default: begin
                ctrl.illegal = 1'b1;
            end
        endcase

        // ----------------------------------------
        // ALU and shifter command
        // ----------------------------------------
        if (ctrl.is_op || instr[6:0] == OPC_OP_IMM) begin
            case (funct3)
                3'b000: ctrl.neg_op2 = ctrl.is_op && instr[30];
                3'b001: ctrl.select_op = SEL_SHIFT;
                3'b010: begin
                    ctrl.neg_op2 = 1'b1;
                    ctrl.slt     = 1'b1;
                end
                3'b011: begin
                    ctrl.neg_op2 = 1'b1;
                    ctrl.sltu    = 1'b1;
                end
                3'b100: ctrl.alu_cmd = CMD_XOR;
                3'b101: begin
                    ctrl.select_op = SEL_SHIFT;
                    ctrl.alu_cmd   = instr[30] ? CMD_OR_SRA : CMD_AND_SRL;
                end
                3'b110: ctrl.alu_cmd = CMD_OR_SRA;
                default: ctrl.alu_cmd = CMD_AND_SRL;
            endcase
        end

        if (ctrl.mem_load || ctrl.mem_store) begin
            case (funct3[1:0])
                2'b00: ctrl.mem_size = MEM_BYTE;
                2'b01: ctrl.mem_size = MEM_HALF;
                default: ctrl.mem_size = MEM_WORD;
            endcase
        end

        // Illegal ones pass through as a harmless bubble
        if (ctrl.illegal) begin
            ctrl          = '0;
            ctrl.illegal  = 1'b1;
            ctrl.mem_size = MEM_NONE;
        end

        ctrl.rs1 = ctrl.rs1_used ? instr[19:15] : '0;
        ctrl.rs2 = ctrl.rs2_used ? instr[24:20] : '0;
        ctrl.rd  = ctrl.wb ? instr[11:7] : '0;
    end

endmodule

`default_nettype wire

// ==== decode/operand_bypass.sv ====
`timescale 1ns/1ps
`default_nettype none

module operand_bypass (
    input  dec_pkg::reg_adr_t    rs,
    input  logic                 used,
    input  dec_pkg::word_t       rdata,
    input  dec_pkg::reg_adr_t    queued_dest,
    input  logic                 queued_valid,
    input  dec_pkg::bypass_src_t exe,
    input  dec_pkg::bypass_src_t mem,
    output dec_pkg::word_t       value,
    output logic                 ready
);

    logic live;
    logic exe_hit;
    logic mem_hit;
    logic queued_hit;
    logic exe_load_hit;

    // x0 and unused sources never take part in forwarding
    assign live = used && (rs != '0);

    assign exe_hit      = live && exe.valid && (exe.dest == rs);
    assign mem_hit      = live && mem.valid && (mem.dest == rs);
    assign queued_hit   = live && queued_valid && (queued_dest == rs);
    assign exe_load_hit = exe_hit && exe.load;

    // Youngest result wins
    always_comb begin
        if (rs == '0) begin
            value = '0;
        end else if (exe_hit) begin
            value = exe.result;
        end else if (mem_hit) begin
            value = mem.result;
        end else begin
            value = rdata;
        end
    end

    // Value not produced yet
    assign ready = !queued_hit && !exe_load_hit;

endmodule

`default_nettype wire

// ==== decode/branch_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module branch_unit (
    input  dec_pkg::dec_ctrl_t ctrl,
    input  dec_pkg::word_t     rs1_value,
    input  dec_pkg::word_t     rs2_value,
    input  dec_pkg::word_t     instr,
    input  dec_pkg::word_t     instr_pc,
    input  dec_pkg::word_t     read_pc,
    output logic               taken,
    output dec_pkg::word_t     next_pc
);

    import dec_pkg::*;

    word_t b_off;
    word_t j_off;
    word_t i_off;
    word_t jalr_sum;
    word_t target;
    logic  equal;
    logic  less_s;
    logic  less_u;
    logic  cond;

    assign b_off = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
    assign j_off = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
    assign i_off = {{20{instr[31]}}, instr[31:20]};

    assign jalr_sum = rs1_value + i_off;

    assign equal  = rs1_value == rs2_value;
    assign less_s = $signed(rs1_value) < $signed(rs2_value);
    assign less_u = rs1_value < rs2_value;

    always_comb begin
        case (ctrl.br_cond)
            BR_EQ:   cond = equal;
            BR_NE:   cond = !equal;
            BR_LT:   cond = less_s;
            BR_GE:   cond = !less_s;
            BR_LTU:  cond = less_u;
            BR_GEU:  cond = !less_u;
            default: cond = 1'b0;
        endcase
    end

    assign taken = (ctrl.is_branch && cond) || ctrl.is_jal || ctrl.is_jalr;

    assign target = ctrl.is_jalr ? {jalr_sum[31:1], 1'b0} :
                    instr_pc + (ctrl.is_jal ? j_off : b_off);

    assign next_pc = taken ? target : read_pc + INC_VALUE;

endmodule

`default_nettype wire

// ==== hdl/dec_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module dec_stage (
    input  logic                 clk,
    input  logic                 reset_n,
    input  dec_pkg::word_t       instr,
    input  dec_pkg::word_t       instr_pc,
    input  dec_pkg::word_t       read_pc,
    input  logic                 if2dec_empty,
    output logic                 if2dec_pop,
    output logic                 if2dec_flush,
    output dec_pkg::reg_adr_t    reg_adr1,
    output dec_pkg::reg_adr_t    reg_adr2,
    input  dec_pkg::word_t       rdata1,
    input  dec_pkg::word_t       rdata2,
    output dec_pkg::word_t       write_pc,
    output logic                 write_pc_enable,
    input  dec_pkg::bypass_src_t bypass_exe,
    input  dec_pkg::bypass_src_t bypass_mem,
    input  logic                 dec2exe_pop,
    output logic                 dec2exe_empty,
    output dec_pkg::dec2exe_t    exe_cmd
);

    import dec_pkg::*;

    localparam int CMD_WIDTH = $bits(dec2exe_t);

    dec_ctrl_t ctrl;
    word_t     rs1_value;
    word_t     rs2_value;
    word_t     op1;
    word_t     next_pc;
    logic      rs1_ready;
    logic      rs2_ready;
    logic      taken;
    logic      load_use;
    logic      stall;
    logic      queue_full;
    dec2exe_t  cmd_in;
    dec2exe_t  cmd_out;

    instr_decoder u_decoder (
        .instr (instr),
        .ctrl  (ctrl)
    );

    operand_bypass u_bypass1 (
        .rs           (ctrl.rs1),
        .used         (ctrl.rs1_used),
        .rdata        (rdata1),
        .queued_dest  (cmd_out.dest),
        .queued_valid (!dec2exe_empty),
        .exe          (bypass_exe),
        .mem          (bypass_mem),
        .value        (rs1_value),
        .ready        (rs1_ready)
    );

    operand_bypass u_bypass2 (
        .rs           (ctrl.rs2),
        .used         (ctrl.rs2_used),
        .rdata        (rdata2),
        .queued_dest  (cmd_out.dest),
        .queued_valid (!dec2exe_empty),
        .exe          (bypass_exe),
        .mem          (bypass_mem),
        .value        (rs2_value),
        .ready        (rs2_ready)
    );

    branch_unit u_branch (
        .ctrl      (ctrl),
        .rs1_value (rs1_value),
        .rs2_value (rs2_value),
        .instr     (instr),
        .instr_pc  (instr_pc),
        .read_pc   (read_pc),
        .taken     (taken),
        .next_pc   (next_pc)
    );

    // ----------------------------------------
    // Stall control
    // ----------------------------------------
    assign load_use = !dec2exe_empty && cmd_out.mem_load && (cmd_out.dest != '0) &&
                      ((ctrl.rs1_used && ctrl.rs1 == cmd_out.dest) ||
                       (ctrl.rs2_used && ctrl.rs2 == cmd_out.dest));

    // Branches resolve here, so their operands must be final
    assign stall = if2dec_empty || queue_full || load_use ||
                   ((ctrl.is_branch || ctrl.is_jalr) && !(rs1_ready && rs2_ready));

    assign if2dec_pop      = !stall;
    assign if2dec_flush    = !stall && taken;
    assign write_pc_enable = !stall;
    assign write_pc        = next_pc;

    assign reg_adr1 = ctrl.rs1;
    assign reg_adr2 = ctrl.rs2;

    // ----------------------------------------
    // Operand selection
    // ----------------------------------------
    always_comb begin
        if (ctrl.is_lui) begin
            op1 = '0;
        end else if (ctrl.is_auipc) begin
            op1 = instr_pc;
        end else if (ctrl.is_jal || ctrl.is_jalr) begin
            // Link value
            op1 = instr_pc + INC_VALUE;
        end else begin
            op1 = rs1_value;
        end
    end

    always_comb begin
        cmd_in.pc              = instr_pc;
        cmd_in.op1             = op1;
        cmd_in.op2             = (ctrl.is_op || ctrl.is_branch) ? rs2_value : ctrl.imm;
        cmd_in.mem_data        = ctrl.is_store ? rs2_value : '0;
        cmd_in.dest            = ctrl.rd;
        cmd_in.radr1           = ctrl.rs1;
        cmd_in.radr2           = ctrl.rs2;
        cmd_in.r1_valid        = rs1_ready;
        cmd_in.r2_valid        = rs2_ready;
        cmd_in.alu_cmd         = ctrl.alu_cmd;
        cmd_in.select_op       = ctrl.select_op;
        cmd_in.neg_op2         = ctrl.neg_op2;
        cmd_in.slt             = ctrl.slt;
        cmd_in.sltu            = ctrl.sltu;
        cmd_in.wb              = ctrl.wb;
        cmd_in.mem_load        = ctrl.mem_load;
        cmd_in.mem_store       = ctrl.mem_store;
        cmd_in.mem_sign_extend = ctrl.mem_sign_extend;
        cmd_in.mem_size        = ctrl.mem_size;
        cmd_in.illegal         = ctrl.illegal;
    end

    dec_fifo #(
        .WIDTH (CMD_WIDTH)
    ) u_dec2exe (
        .clk     (clk),
        .reset_n (reset_n),
        .din     (cmd_in),
        .push    (!stall),
        .pop     (dec2exe_pop),
        .dout    (cmd_out),
        .full    (queue_full),
        .empty   (dec2exe_empty)
    );

    assign exe_cmd = cmd_out;

endmodule

`default_nettype wire

// ==== verif/dec_stage_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module dec_stage_tb;

    import dec_pkg::*;

    localparam int NUM_INSTR = 2000;
    localparam int TIMEOUT   = 200;

    logic        clk;
    logic        reset_n;
    word_t       instr;
    word_t       instr_pc;
    word_t       read_pc;
    logic        if2dec_empty;
    logic        if2dec_pop;
    logic        if2dec_flush;
    reg_adr_t    reg_adr1;
    reg_adr_t    reg_adr2;
    word_t       rdata1;
    word_t       rdata2;
    word_t       write_pc;
    logic        write_pc_enable;
    bypass_src_t bypass_exe;
    bypass_src_t bypass_mem;
    logic        dec2exe_pop;
    logic        dec2exe_empty;
    dec2exe_t    exe_cmd;

    // Expected entries of the decode-to-execute queue
    dec2exe_t    sb[$];
    int          pop_count;
    int          hold_cycles;
    word_t       next_instr_pc;

    dec2exe_t    exp_cmd;
    dec2exe_t    head;
    word_t       exp_pc;
    logic        exp_taken;
    logic        exp_pop;
    logic        queued;
    logic        load_use;
    logic        is_br;

    dec_stage UUT (
        .clk             (clk),
        .reset_n         (reset_n),
        .instr           (instr),
        .instr_pc        (instr_pc),
        .read_pc         (read_pc),
        .if2dec_empty    (if2dec_empty),
        .if2dec_pop      (if2dec_pop),
        .if2dec_flush    (if2dec_flush),
        .reg_adr1        (reg_adr1),
        .reg_adr2        (reg_adr2),
        .rdata1          (rdata1),
        .rdata2          (rdata2),
        .write_pc        (write_pc),
        .write_pc_enable (write_pc_enable),
        .bypass_exe      (bypass_exe),
        .bypass_mem      (bypass_mem),
        .dec2exe_pop     (dec2exe_pop),
        .dec2exe_empty   (dec2exe_empty),
        .exe_cmd         (exe_cmd)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Register file holds its own number in every byte
    function automatic word_t reg_contents(input reg_adr_t r);
        return {3'b000, r, 3'b000, r, 3'b000, r, 3'b000, r};
    endfunction

    assign rdata1 = reg_contents(reg_adr1);
    assign rdata2 = reg_contents(reg_adr2);

    // ----------------------------------------
    // Reference model
    // ----------------------------------------
    function automatic logic is_legal(input word_t ins);
        logic [2:0] f3;
        logic [6:0] f7;
        f3 = ins[14:12];
        f7 = ins[31:25];
        case (ins[6:0])
            OPC_OP:     return f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
            OPC_OP_IMM: begin
                if (f3 == 3'd1) return f7 == 7'h00;
                if (f3 == 3'd5) return f7 == 7'h00 || f7 == 7'h20;
                return 1'b1;
            end
            OPC_LOAD:   return f3 != 3'd3 && f3 != 3'd6 && f3 != 3'd7;
            OPC_STORE:  return f3 == 3'd0 || f3 == 3'd1 || f3 == 3'd2;
            OPC_BRANCH: return f3 != 3'd2 && f3 != 3'd3;
            OPC_LUI, OPC_AUIPC, OPC_JAL: return 1'b1;
            OPC_JALR:   return f3 == 3'd0;
            default:    return 1'b0;
        endcase
    endfunction

    function automatic word_t src_value(input reg_adr_t rs, input bypass_src_t exe,
                                        input bypass_src_t mem);
        if (rs == '0) return '0;
        if (exe.valid && exe.dest == rs) return exe.result;
        if (mem.valid && mem.dest == rs) return mem.result;
        return reg_contents(rs);
    endfunction

    function automatic logic src_ready(input reg_adr_t rs, input bypass_src_t exe,
                                       input reg_adr_t qdest, input logic qvalid);
        if (rs == '0) return 1'b1;
        return !((qvalid && qdest == rs) || (exe.valid && exe.dest == rs && exe.load));
    endfunction

    function automatic dec2exe_t expected_cmd(input word_t ins, input word_t pc,
                                              input bypass_src_t exe, input bypass_src_t mem,
                                              input reg_adr_t qdest, input logic qvalid);
        dec2exe_t   c;
        logic [6:0] opc;
        logic [2:0] f3;
        word_t      imm;
        opc        = ins[6:0];
        f3         = ins[14:12];
        imm        = '0;
        c          = '0;
        c.pc       = pc;
        c.mem_size = MEM_NONE;
        c.r1_valid = 1'b1;
        c.r2_valid = 1'b1;
        if (!is_legal(ins)) begin
            c.illegal = 1'b1;
            return c;
        end
        c.wb = opc != OPC_STORE && opc != OPC_BRANCH;
        if (opc != OPC_LUI && opc != OPC_AUIPC && opc != OPC_JAL) c.radr1 = ins[19:15];
        if (opc == OPC_OP || opc == OPC_STORE || opc == OPC_BRANCH) c.radr2 = ins[24:20];
        if (c.wb) c.dest = ins[11:7];
        c.r1_valid = src_ready(c.radr1, exe, qdest, qvalid);
        c.r2_valid = src_ready(c.radr2, exe, qdest, qvalid);

        if (opc == OPC_OP_IMM || opc == OPC_LOAD) begin
            imm = {{20{ins[31]}}, ins[31:20]};
        end else if (opc == OPC_STORE) begin
            imm = {{20{ins[31]}}, ins[31:25], ins[11:7]};
        end else if (opc == OPC_LUI || opc == OPC_AUIPC) begin
            imm = {ins[31:12], 12'h000};
        end

        case (opc)
            OPC_LUI:           c.op1 = '0;
            OPC_AUIPC:         c.op1 = pc;
            OPC_JAL, OPC_JALR: c.op1 = pc + INC_VALUE;
            default:           c.op1 = src_value(c.radr1, exe, mem);
        endcase
        c.op2 = (opc == OPC_OP || opc == OPC_BRANCH) ? src_value(c.radr2, exe, mem) : imm;
        if (opc == OPC_STORE) c.mem_data = src_value(c.radr2, exe, mem);

        if (opc == OPC_OP || opc == OPC_OP_IMM) begin
            case (f3)
                3'd0: c.neg_op2 = opc == OPC_OP && ins[30];
                3'd1: c.select_op = SEL_SHIFT;
                3'd2: begin
                    c.neg_op2 = 1'b1;
                    c.slt     = 1'b1;
                end
                3'd3: begin
                    c.neg_op2 = 1'b1;
                    c.sltu    = 1'b1;
                end
                3'd4: c.alu_cmd = CMD_XOR;
                3'd5: begin
                    c.select_op = SEL_SHIFT;
                    c.alu_cmd   = ins[30] ? CMD_OR_SRA : CMD_AND_SRL;
                end
                3'd6: c.alu_cmd = CMD_OR_SRA;
                default: c.alu_cmd = CMD_AND_SRL;
            endcase
        end

        if (opc == OPC_LOAD || opc == OPC_STORE) begin
            c.mem_load        = opc == OPC_LOAD;
            c.mem_store       = opc == OPC_STORE;
            c.mem_sign_extend = opc == OPC_LOAD && f3[2:1] == 2'b00;
            case (f3[1:0])
                2'b00:   c.mem_size = MEM_BYTE;
                2'b01:   c.mem_size = MEM_HALF;
                default: c.mem_size = MEM_WORD;
            endcase
        end
        return c;
    endfunction

    function automatic word_t expected_next_pc(input word_t ins, input word_t pc,
                                               input word_t rpc, input bypass_src_t exe,
                                               input bypass_src_t mem, output logic taken);
        word_t a;
        word_t b;
        word_t sum;
        word_t target;
        a      = src_value(ins[19:15], exe, mem);
        b      = src_value(ins[24:20], exe, mem);
        sum    = a + {{20{ins[31]}}, ins[31:20]};
        taken  = 1'b0;
        target = '0;
        if (is_legal(ins)) begin
            case (ins[6:0])
                OPC_BRANCH: begin
                    case (ins[14:12])
                        3'd0:    taken = a == b;
                        3'd1:    taken = a != b;
                        3'd4:    taken = $signed(a) < $signed(b);
                        3'd5:    taken = $signed(a) >= $signed(b);
                        3'd6:    taken = a < b;
                        default: taken = a >= b;
                    endcase
                    target = pc + {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
                end
                OPC_JAL: begin
                    taken  = 1'b1;
                    target = pc + {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
                end
                OPC_JALR: begin
                    taken  = 1'b1;
                    target = {sum[31:1], 1'b0};
                end
                default: taken = 1'b0;
            endcase
        end
        return taken ? target : rpc + INC_VALUE;
    endfunction

    // ----------------------------------------
    // Compare tasks
    // ----------------------------------------
    task automatic abort_run();
        $display("ERRORS FOUND");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_cmd(input dec2exe_t got, input dec2exe_t exp);
        if (got !== exp) begin
            $display("Mismatch exe_cmd: got %h, expected %h", got, exp);
            abort_run();
        end
    endtask

    task automatic check_pc(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("Mismatch %s: got %h, expected %h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_adr(input string name, input reg_adr_t got, input reg_adr_t exp);
        if (got !== exp) begin
            $display("Mismatch %s: got %h, expected %h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Mismatch %s: got %h, expected %h", name, got, exp);
            abort_run();
        end
    endtask

    // Outputs settle half a cycle after the inputs move
    always @(negedge clk) begin
        if (reset_n) begin
            queued = sb.size() != 0;
            head   = '0;
            if (queued) begin
                head = sb[0];
                check_cmd(exe_cmd, head);
            end
            check_flag("dec2exe_empty", dec2exe_empty, !queued);
            exp_cmd  = expected_cmd(instr, instr_pc, bypass_exe, bypass_mem, head.dest, queued);
            exp_pc   = expected_next_pc(instr, instr_pc, read_pc, bypass_exe, bypass_mem,
                                        exp_taken);
            check_adr("reg_adr1", reg_adr1, exp_cmd.radr1);
            check_adr("reg_adr2", reg_adr2, exp_cmd.radr2);
            load_use = queued && head.mem_load && head.dest != '0 &&
                       (exp_cmd.radr1 == head.dest || exp_cmd.radr2 == head.dest);
            is_br    = !exp_cmd.illegal &&
                       (instr[6:0] == OPC_BRANCH || instr[6:0] == OPC_JALR);
            exp_pop  = !if2dec_empty && !queued && !load_use &&
                       !(is_br && !(exp_cmd.r1_valid && exp_cmd.r2_valid));
            check_flag("if2dec_pop", if2dec_pop, exp_pop);
            check_flag("write_pc_enable", write_pc_enable, exp_pop);
            check_flag("if2dec_flush", if2dec_flush, exp_pop && exp_taken);
            if (queued && dec2exe_pop) begin
                void'(sb.pop_front());
            end
            if (exp_pop) begin
                check_pc("write_pc", write_pc, exp_pc);
                sb.push_back(exp_cmd);
                next_instr_pc = exp_taken ? exp_pc : instr_pc + INC_VALUE;
                pop_count++;
            end
        end
    end

    // ----------------------------------------
    // Stimulus
    // ----------------------------------------
    function automatic bypass_src_t random_bypass();
        bypass_src_t b;
        logic [31:0] r;
        r        = $urandom;
        b.valid  = r[0];
        b.dest   = {2'b00, r[3:1]};
        b.load   = r[5:4] == 2'b00;
        b.result = $urandom;
        return b;
    endfunction

    function automatic word_t random_instr();
        logic [31:0] r;
        word_t       ins;
        int          cls;
        r          = $urandom;
        ins        = $urandom;
        cls        = $urandom % 10;
        ins[11:7]  = {2'b00, r[2:0]};
        ins[19:15] = {2'b00, r[10:8]};
        ins[24:20] = {2'b00, r[13:11]};
        case (cls)
            0: begin
                ins[6:0]   = OPC_OP;
                ins[31:25] = r[17] ? (r[16] ? r[24:18] : 7'h20) : 7'h00;
            end
            1: begin
                ins[6:0] = OPC_OP_IMM;
                if (ins[13:12] == 2'b01) ins[31:25] = r[17] ? (r[16] ? r[24:18] : 7'h20) : 7'h00;
            end
            2: ins[6:0] = OPC_LOAD;
            3: ins[6:0] = OPC_STORE;
            4: ins[6:0] = OPC_BRANCH;
            5: ins[6:0] = OPC_LUI;
            6: ins[6:0] = OPC_AUIPC;
            7: ins[6:0] = OPC_JAL;
            8: begin
                ins[6:0] = OPC_JALR;
                if (r[19:18] != 2'b00) ins[14:12] = 3'b000;
            end
            default: ins[6:0] = r[31:25];
        endcase
        return ins;
    endfunction

    task automatic drive_side();
        logic [31:0] r;
        r = $urandom;
        bypass_exe <= random_bypass();
        bypass_mem <= random_bypass();
        if (hold_cycles > 0) begin
            dec2exe_pop <= 1'b0;
            hold_cycles--;
        end else begin
            dec2exe_pop <= r[0];
        end
    endtask

    task automatic idle_cycle();
        if2dec_empty <= 1'b1;
        drive_side();
        @(posedge clk);
    endtask

    task automatic present_instr(input word_t ins, input word_t pc);
        int start_count;
        int cycles;
        start_count = pop_count;
        cycles      = 0;
        instr        <= ins;
        instr_pc     <= pc;
        read_pc      <= pc + 32'd8;
        if2dec_empty <= 1'b0;
        drive_side();
        @(posedge clk);
        while (pop_count == start_count) begin
            drive_side();
            @(posedge clk);
            cycles++;
            if (cycles > TIMEOUT) begin
                $display("Timeout: instruction %h at pc %h was never popped", ins, pc);
                abort_run();
            end
        end
    endtask

    task automatic drain_queue();
        int cycles;
        cycles      = 0;
        hold_cycles = 0;
        while (sb.size() != 0) begin
            idle_cycle();
            cycles++;
            if (cycles > TIMEOUT) begin
                $display("Timeout: the execute queue was never emptied");
                abort_run();
            end
        end
        repeat (2) idle_cycle();
    endtask

    initial begin : stimulus
        int          n;
        word_t       pc;
        logic [31:0] r;
        void'($urandom(32'h170f_cb27));
        pop_count     = 0;
        hold_cycles   = 0;
        next_instr_pc = '0;
        reset_n       = 1'b0;
        instr         = 32'h0000_0013;
        instr_pc      = '0;
        read_pc       = '0;
        if2dec_empty  = 1'b1;
        bypass_exe    = '0;
        bypass_mem    = '0;
        dec2exe_pop   = 1'b0;

        repeat (16) @(posedge clk);
        reset_n <= 1'b1;
        repeat (3) idle_cycle();

        pc = 32'h0000_1000;
        for (n = 0; n < NUM_INSTR; n++) begin
            r = $urandom;
            // Execute side stalls now and then
            if (n % 40 == 20) hold_cycles = 8;
            if (r[1:0] == 2'b00) begin
                repeat (int'(r[3:2]) + 1) idle_cycle();
            end
            present_instr(random_instr(), pc);
            pc = next_instr_pc;
        end
        drain_queue();

        $display("NO ERRORS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb.f ====
common/dec_pkg.sv
hdl/dec_fifo.sv
decode/instr_decoder.sv
decode/operand_bypass.sv
decode/branch_unit.sv
hdl/dec_stage.sv
verif/dec_stage_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -f tb.f --top-module dec_stage_tb -o dec_stage_sim
./obj_dir/dec_stage_sim | tee sim.log

if grep -q "ERRORS FOUND" sim.log; then
    echo "Simulation failed"
    exit 1
fi
echo "Simulation passed"
